//--- hw/xbar_pkg.sv
// Crossbar widths, address map, response code and responder state types
`default_nettype none

package xbar_pkg;

  localparam int unsigned num_requesters = 2;
  localparam int unsigned num_targets    = 2;
  localparam int unsigned addr_width     = 32;
  localparam int unsigned data_width     = 32;
  // Extra ID bits that name the requester on the target side
  localparam int unsigned req_sel_width  = 1;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_e;

  // End address is exclusive
  typedef struct packed {
    logic                  idx;
    logic [addr_width-1:0] start_addr;
    logic [addr_width-1:0] end_addr;
  } rule_t;

  localparam rule_t addr_map [0:1] = '{
    '{idx: 1'b0, start_addr: 32'h0000_0000, end_addr: 32'h0000_1000},
    '{idx: 1'b1, start_addr: 32'h0000_1000, end_addr: 32'h0000_2000}
  };

  typedef enum logic {
    ST_IDLE,
    ST_RESPOND
  } responder_state_e;

endpackage

`default_nettype wire

//--- hw/addr_decoder.sv
// Address decoder that maps a read address to a target index
`default_nettype none

module addr_decoder
  import xbar_pkg::*;
(
  input  logic [addr_width-1:0] addr_i,
  output logic                  idx_o,
  output logic                  dec_error_o
);

  // Walk all rules, a hit clears the error flag
  always_comb begin
    idx_o       = 1'b0;
    dec_error_o = 1'b1;
    for (int i = 0; i < $size(addr_map); i++) begin
      if ((addr_i >= addr_map[i].start_addr) && (addr_i < addr_map[i].end_addr)) begin
        idx_o       = addr_map[i].idx;
        dec_error_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/read_demux.sv
// Per-requester read demultiplexer with outstanding transaction tracking
`default_nettype none

module read_demux
  import xbar_pkg::*;
#(
  parameter int unsigned IdWidth  = 4,
  parameter int unsigned MaxTrans = 4
) (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  // Requester side
  input  logic                                      ar_valid_i,
  output logic                                      ar_ready_o,
  input  logic [addr_width-1:0]                     ar_addr_i,
  input  logic [IdWidth-1:0]                        ar_id_i,
  output logic                                      r_valid_o,
  input  logic                                      r_ready_i,
  output logic [data_width-1:0]                     r_data_o,
  output logic [IdWidth-1:0]                        r_id_o,
  output resp_e                                     r_resp_o,
  // Destination side, last entry is the error responder
  output logic [num_targets:0]                      dst_ar_valid_o,
  input  logic [num_targets:0]                      dst_ar_ready_i,
  output logic [num_targets:0][addr_width-1:0]      dst_ar_addr_o,
  output logic [num_targets:0][IdWidth-1:0]         dst_ar_id_o,
  input  logic [num_targets:0]                      dst_r_valid_i,
  output logic [num_targets:0]                      dst_r_ready_o,
  input  logic [num_targets:0][data_width-1:0]      dst_r_data_i,
  input  logic [num_targets:0][IdWidth-1:0]         dst_r_id_i,
  input  resp_e [num_targets:0]                     dst_r_resp_i
);

  localparam int unsigned SelWidth = $clog2(num_targets + 1);
  localparam int unsigned CntWidth = $clog2(MaxTrans + 1);

  logic                dec_idx;
  logic                dec_error;
  logic [SelWidth-1:0] ar_select;
  logic [SelWidth-1:0] sel_q;
  logic [CntWidth-1:0] cnt_q;
  logic                ar_stall;
  logic                ar_hs;
  logic                r_hs;

  addr_decoder u_addr_decoder (
    .addr_i      (ar_addr_i),
    .idx_o       (dec_idx),
    .dec_error_o (dec_error)
  );

  // Unmapped reads go to the last destination
  assign ar_select = dec_error ? SelWidth'(num_targets) : SelWidth'(dec_idx);

  // Only one destination may be in flight, so responses come back in order
  assign ar_stall = (cnt_q == CntWidth'(MaxTrans)) ||
                    ((cnt_q != '0) && (ar_select != sel_q));

  assign ar_ready_o = !ar_stall && dst_ar_ready_i[ar_select];
  assign ar_hs      = ar_valid_i && ar_ready_o;

  always_comb begin
    for (int i = 0; i <= num_targets; i++) begin
      dst_ar_valid_o[i] = ar_valid_i && !ar_stall && (ar_select == SelWidth'(i));
      dst_ar_addr_o[i]  = ar_addr_i;
      dst_ar_id_o[i]    = ar_id_i;
      dst_r_ready_o[i]  = r_ready_i && (sel_q == SelWidth'(i));
    end
  end

  // Response path follows the destination in flight
  assign r_valid_o = dst_r_valid_i[sel_q];
  assign r_data_o  = dst_r_data_i[sel_q];
  assign r_id_o    = dst_r_id_i[sel_q];
  assign r_resp_o  = dst_r_resp_i[sel_q];
  assign r_hs      = r_valid_o && r_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
      sel_q <= '0;
    end else begin
      if (ar_hs) begin
        sel_q <= ar_select;
      end
      case ({ar_hs, r_hs})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/decerr_responder.sv
// Error responder that answers unmapped reads with DECERR
`default_nettype none

module decerr_responder
  import xbar_pkg::*;
#(
  parameter int unsigned IdWidth = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  logic [IdWidth-1:0]    ar_id_i,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output logic [data_width-1:0] r_data_o,
  output logic [IdWidth-1:0]    r_id_o,
  output resp_e                 r_resp_o
);

  responder_state_e   state_q;
  responder_state_e   state_d;
  logic [IdWidth-1:0] id_q;

  assign ar_ready_o = (state_q == ST_IDLE);
  assign r_valid_o  = (state_q == ST_RESPOND);
  assign r_data_o   = '0;
  assign r_id_o     = id_q;
  assign r_resp_o   = RESP_DECERR;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (ar_valid_i) state_d = ST_RESPOND;
      ST_RESPOND: if (r_ready_i) state_d = ST_IDLE;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Echo the ID of the accepted read
  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      id_q <= ar_id_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/read_mux.sv
// Per-target round-robin read multiplexer with ID-based response routing
`default_nettype none

module read_mux
  import xbar_pkg::*;
#(
  parameter int unsigned IdWidth = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  // Requester side
  input  logic [num_requesters-1:0]                    src_ar_valid_i,
  output logic [num_requesters-1:0]                    src_ar_ready_o,
  input  logic [num_requesters-1:0][addr_width-1:0]    src_ar_addr_i,
  input  logic [num_requesters-1:0][IdWidth-1:0]       src_ar_id_i,
  output logic [num_requesters-1:0]                    src_r_valid_o,
  input  logic [num_requesters-1:0]                    src_r_ready_i,
  output logic [num_requesters-1:0][data_width-1:0]    src_r_data_o,
  output logic [num_requesters-1:0][IdWidth-1:0]       src_r_id_o,
  output resp_e [num_requesters-1:0]                   src_r_resp_o,
  // Target side
  output logic                                         tgt_ar_valid_o,
  input  logic                                         tgt_ar_ready_i,
  output logic [addr_width-1:0]                        tgt_ar_addr_o,
  output logic [IdWidth+req_sel_width-1:0]             tgt_ar_id_o,
  input  logic                                         tgt_r_valid_i,
  output logic                                         tgt_r_ready_o,
  input  logic [data_width-1:0]                        tgt_r_data_i,
  input  logic [IdWidth+req_sel_width-1:0]             tgt_r_id_i,
  input  resp_e                                        tgt_r_resp_i
);

  localparam int unsigned TgtIdWidth = IdWidth + req_sel_width;

  logic [req_sel_width-1:0] grant_q;
  logic                     lock_q;
  logic [req_sel_width-1:0] rr_pick;
  logic [req_sel_width-1:0] grant;
  logic [req_sel_width-1:0] r_sel;

  // Search starts just after the last grant, nearest requester wins
  always_comb begin
    int cand;
    rr_pick = grant_q;
    for (int k = num_requesters; k >= 1; k--) begin
      cand = (int'(grant_q) + k) % num_requesters;
      if (src_ar_valid_i[cand]) begin
        rr_pick = req_sel_width'(cand);
      end
    end
  end

  // A stalled AR keeps its grant
  assign grant = lock_q ? grant_q : rr_pick;

  assign tgt_ar_valid_o = src_ar_valid_i[grant];
  assign tgt_ar_addr_o  = src_ar_addr_i[grant];
  assign tgt_ar_id_o    = {grant, src_ar_id_i[grant]};

  // Requester index sits in the top ID bits
  assign r_sel         = tgt_r_id_i[TgtIdWidth-1 -: req_sel_width];
  assign tgt_r_ready_o = src_r_ready_i[r_sel];

  always_comb begin
    for (int i = 0; i < num_requesters; i++) begin
      src_ar_ready_o[i] = tgt_ar_ready_i && (grant == req_sel_width'(i));
      src_r_valid_o[i]  = tgt_r_valid_i && (r_sel == req_sel_width'(i));
      src_r_data_o[i]   = tgt_r_data_i;
      src_r_id_o[i]     = tgt_r_id_i[IdWidth-1:0];
      src_r_resp_o[i]   = tgt_r_resp_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      grant_q <= '0;
      lock_q  <= 1'b0;
    end else begin
      lock_q <= tgt_ar_valid_o && !tgt_ar_ready_i;
      if (tgt_ar_valid_o) begin
        grant_q <= grant;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/read_xbar.sv
// Read-only crossbar top level with demuxes, error responders and muxes
`default_nettype none

module read_xbar
  import xbar_pkg::*;
#(
  parameter int unsigned IdWidth  = 4,
  parameter int unsigned MaxTrans = 4
) (
  input  logic                                                clk_i,
  input  logic                                                rst_i,
  // Requester ports
  input  logic [num_requesters-1:0]                           req_ar_valid_i,
  output logic [num_requesters-1:0]                           req_ar_ready_o,
  input  logic [num_requesters-1:0][addr_width-1:0]           req_ar_addr_i,
  input  logic [num_requesters-1:0][IdWidth-1:0]              req_ar_id_i,
  output logic [num_requesters-1:0]                           req_r_valid_o,
  input  logic [num_requesters-1:0]                           req_r_ready_i,
  output logic [num_requesters-1:0][data_width-1:0]           req_r_data_o,
  output logic [num_requesters-1:0][IdWidth-1:0]              req_r_id_o,
  output resp_e [num_requesters-1:0]                          req_r_resp_o,
  // Target ports
  output logic [num_targets-1:0]                              tgt_ar_valid_o,
  input  logic [num_targets-1:0]                              tgt_ar_ready_i,
  output logic [num_targets-1:0][addr_width-1:0]              tgt_ar_addr_o,
  output logic [num_targets-1:0][IdWidth+req_sel_width-1:0]   tgt_ar_id_o,
  input  logic [num_targets-1:0]                              tgt_r_valid_i,
  output logic [num_targets-1:0]                              tgt_r_ready_o,
  input  logic [num_targets-1:0][data_width-1:0]              tgt_r_data_i,
  input  logic [num_targets-1:0][IdWidth+req_sel_width-1:0]   tgt_r_id_i,
  input  resp_e [num_targets-1:0]                             tgt_r_resp_i
);

  // Demux side, indexed by requester then destination
  logic  [num_requesters-1:0][num_targets:0]                  dmx_ar_valid;
  logic  [num_requesters-1:0][num_targets:0]                  dmx_ar_ready;
  logic  [num_requesters-1:0][num_targets:0][addr_width-1:0]  dmx_ar_addr;
  logic  [num_requesters-1:0][num_targets:0][IdWidth-1:0]     dmx_ar_id;
  logic  [num_requesters-1:0][num_targets:0]                  dmx_r_valid;
  logic  [num_requesters-1:0][num_targets:0]                  dmx_r_ready;
  logic  [num_requesters-1:0][num_targets:0][data_width-1:0]  dmx_r_data;
  logic  [num_requesters-1:0][num_targets:0][IdWidth-1:0]     dmx_r_id;
  resp_e [num_requesters-1:0][num_targets:0]                  dmx_r_resp;

  // Mux side, indexed by target then requester
  logic  [num_targets-1:0][num_requesters-1:0]                mux_ar_valid;
  logic  [num_targets-1:0][num_requesters-1:0]                mux_ar_ready;
  logic  [num_targets-1:0][num_requesters-1:0][addr_width-1:0] mux_ar_addr;
  logic  [num_targets-1:0][num_requesters-1:0][IdWidth-1:0]   mux_ar_id;
  logic  [num_targets-1:0][num_requesters-1:0]                mux_r_valid;
  logic  [num_targets-1:0][num_requesters-1:0]                mux_r_ready;
  logic  [num_targets-1:0][num_requesters-1:0][data_width-1:0] mux_r_data;
  logic  [num_targets-1:0][num_requesters-1:0][IdWidth-1:0]   mux_r_id;
  resp_e [num_targets-1:0][num_requesters-1:0]                mux_r_resp;

  for (genvar i = 0; i < num_requesters; i++) begin : gen_req
    read_demux #(
      .IdWidth  (IdWidth),
      .MaxTrans (MaxTrans)
    ) u_read_demux (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .ar_valid_i     (req_ar_valid_i[i]),
      .ar_ready_o     (req_ar_ready_o[i]),
      .ar_addr_i      (req_ar_addr_i[i]),
      .ar_id_i        (req_ar_id_i[i]),
      .r_valid_o      (req_r_valid_o[i]),
      .r_ready_i      (req_r_ready_i[i]),
      .r_data_o       (req_r_data_o[i]),
      .r_id_o         (req_r_id_o[i]),
      .r_resp_o       (req_r_resp_o[i]),
      .dst_ar_valid_o (dmx_ar_valid[i]),
      .dst_ar_ready_i (dmx_ar_ready[i]),
      .dst_ar_addr_o  (dmx_ar_addr[i]),
      .dst_ar_id_o    (dmx_ar_id[i]),
      .dst_r_valid_i  (dmx_r_valid[i]),
      .dst_r_ready_o  (dmx_r_ready[i]),
      .dst_r_data_i   (dmx_r_data[i]),
      .dst_r_id_i     (dmx_r_id[i]),
      .dst_r_resp_i   (dmx_r_resp[i])
    );

    // Unmapped reads end here
    decerr_responder #(
      .IdWidth (IdWidth)
    ) u_decerr_responder (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ar_valid_i (dmx_ar_valid[i][num_targets]),
      .ar_ready_o (dmx_ar_ready[i][num_targets]),
      .ar_id_i    (dmx_ar_id[i][num_targets]),
      .r_valid_o  (dmx_r_valid[i][num_targets]),
      .r_ready_i  (dmx_r_ready[i][num_targets]),
      .r_data_o   (dmx_r_data[i][num_targets]),
      .r_id_o     (dmx_r_id[i][num_targets]),
      .r_resp_o   (dmx_r_resp[i][num_targets])
    );

    for (genvar j = 0; j < num_targets; j++) begin : gen_cross
      assign mux_ar_valid[j][i] = dmx_ar_valid[i][j];
      assign dmx_ar_ready[i][j] = mux_ar_ready[j][i];
      assign mux_ar_addr[j][i]  = dmx_ar_addr[i][j];
      assign mux_ar_id[j][i]    = dmx_ar_id[i][j];
      assign dmx_r_valid[i][j]  = mux_r_valid[j][i];
      assign mux_r_ready[j][i]  = dmx_r_ready[i][j];
      assign dmx_r_data[i][j]   = mux_r_data[j][i];
      assign dmx_r_id[i][j]     = mux_r_id[j][i];
      assign dmx_r_resp[i][j]   = mux_r_resp[j][i];
    end
  end

  for (genvar j = 0; j < num_targets; j++) begin : gen_tgt
    read_mux #(
      .IdWidth (IdWidth)
    ) u_read_mux (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .src_ar_valid_i (mux_ar_valid[j]),
      .src_ar_ready_o (mux_ar_ready[j]),
      .src_ar_addr_i  (mux_ar_addr[j]),
      .src_ar_id_i    (mux_ar_id[j]),
      .src_r_valid_o  (mux_r_valid[j]),
      .src_r_ready_i  (mux_r_ready[j]),
      .src_r_data_o   (mux_r_data[j]),
      .src_r_id_o     (mux_r_id[j]),
      .src_r_resp_o   (mux_r_resp[j]),
      .tgt_ar_valid_o (tgt_ar_valid_o[j]),
      .tgt_ar_ready_i (tgt_ar_ready_i[j]),
      .tgt_ar_addr_o  (tgt_ar_addr_o[j]),
      .tgt_ar_id_o    (tgt_ar_id_o[j]),
      .tgt_r_valid_i  (tgt_r_valid_i[j]),
      .tgt_r_ready_o  (tgt_r_ready_o[j]),
      .tgt_r_data_i   (tgt_r_data_i[j]),
      .tgt_r_id_i     (tgt_r_id_i[j]),
      .tgt_r_resp_i   (tgt_r_resp_i[j])
    );
  end

endmodule

`default_nettype wire

//--- verification/tb_target_model.sv
// Behavioral memory target that answers one read at a time after a fixed delay
`default_nettype none

module tb_target_model
  import xbar_pkg::*;
#(
  parameter int unsigned           IdWidth     = 5,
  parameter int unsigned           Delay       = 2,
  parameter logic [data_width-1:0] DataPattern = 32'hA5A5_0000
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  logic [addr_width-1:0] ar_addr_i,
  input  logic [IdWidth-1:0]    ar_id_i,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output logic [data_width-1:0] r_data_o,
  output logic [IdWidth-1:0]    r_id_o,
  output resp_e                 r_resp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic                  ar_taken = 1'b0;
  logic                  r_taken  = 1'b0;
  logic                  busy     = 1'b0;
  logic [addr_width-1:0] addr_q   = '0;
  logic [IdWidth-1:0]    id_q     = '0;
  int unsigned           delay_cnt;

  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_id_o     = '0;
    r_resp_o   = RESP_OKAY;
  end

  // Handshakes happen on the rising edge
  always @(posedge clk_i) begin
    ar_taken = ar_valid_i && ar_ready_o;
    r_taken  = r_valid_o && r_ready_i;
    if (ar_taken) begin
      addr_q = ar_addr_i;
      id_q   = ar_id_i;
    end
  end

  // Outputs change on the falling edge only
  always @(negedge clk_i) begin
    if (rst_i) begin
      busy       = 1'b0;
      ar_ready_o = 1'b0;
      r_valid_o  = 1'b0;
    end else if (r_taken) begin
      r_valid_o  = 1'b0;
      busy       = 1'b0;
      ar_ready_o = 1'b1;
    end else if (ar_taken) begin
      busy       = 1'b1;
      ar_ready_o = 1'b0;
      delay_cnt  = Delay - 1;
    end else if (busy && !r_valid_o) begin
      if (delay_cnt <= 1) begin
        r_valid_o = 1'b1;
        r_data_o  = addr_q ^ DataPattern;
        r_id_o    = id_q;
        r_resp_o  = RESP_OKAY;
      end else begin
        delay_cnt = delay_cnt - 1;
      end
    end else if (!busy) begin
      ar_ready_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_read_xbar.sv
// Crossbar testbench with clock, reset, stimulus, scoreboard checks and reporting
`default_nettype none

module tb_read_xbar
  import xbar_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned IdWidth     = 4;
  localparam int unsigned MaxTrans    = 4;
  localparam int unsigned TgtIdWidth  = IdWidth + req_sel_width;
  localparam int unsigned TgtDelay    = 2;
  localparam logic [31:0] DataPattern = 32'hA5A5_0000;
  localparam logic [31:0] Seed        = 32'h050bb654;
  localparam int          Timeout     = 200;

  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [IdWidth-1:0]    id;
    logic [data_width-1:0] data;
    resp_e                 resp;
  } exp_t;

  logic                                             clk_i;
  logic                                             rst_i;
  logic  [num_requesters-1:0]                       req_ar_valid_i;
  logic  [num_requesters-1:0]                       req_ar_ready_o;
  logic  [num_requesters-1:0][addr_width-1:0]       req_ar_addr_i;
  logic  [num_requesters-1:0][IdWidth-1:0]          req_ar_id_i;
  logic  [num_requesters-1:0]                       req_r_valid_o;
  logic  [num_requesters-1:0]                       req_r_ready_i;
  logic  [num_requesters-1:0][data_width-1:0]       req_r_data_o;
  logic  [num_requesters-1:0][IdWidth-1:0]          req_r_id_o;
  resp_e [num_requesters-1:0]                       req_r_resp_o;
  logic  [num_targets-1:0]                          tgt_ar_valid_o;
  logic  [num_targets-1:0]                          tgt_ar_ready_i;
  logic  [num_targets-1:0][addr_width-1:0]          tgt_ar_addr_o;
  logic  [num_targets-1:0][TgtIdWidth-1:0]          tgt_ar_id_o;
  logic  [num_targets-1:0]                          tgt_r_valid_i;
  logic  [num_targets-1:0]                          tgt_r_ready_o;
  logic  [num_targets-1:0][data_width-1:0]          tgt_r_data_i;
  logic  [num_targets-1:0][TgtIdWidth-1:0]          tgt_r_id_i;
  resp_e [num_targets-1:0]                          tgt_r_resp_i;

  // Expected responses per requester in issue order
  exp_t exp_q [num_requesters][$];
  int   tgt_ar_count [num_targets];
  int   errors;
  int   tests_passed;
  int   tests_failed;
  logic random_ready;

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  read_xbar #(
    .IdWidth  (IdWidth),
    .MaxTrans (MaxTrans)
  ) read_xbar_inst (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_ar_valid_i (req_ar_valid_i),
    .req_ar_ready_o (req_ar_ready_o),
    .req_ar_addr_i  (req_ar_addr_i),
    .req_ar_id_i    (req_ar_id_i),
    .req_r_valid_o  (req_r_valid_o),
    .req_r_ready_i  (req_r_ready_i),
    .req_r_data_o   (req_r_data_o),
    .req_r_id_o     (req_r_id_o),
    .req_r_resp_o   (req_r_resp_o),
    .tgt_ar_valid_o (tgt_ar_valid_o),
    .tgt_ar_ready_i (tgt_ar_ready_i),
    .tgt_ar_addr_o  (tgt_ar_addr_o),
    .tgt_ar_id_o    (tgt_ar_id_o),
    .tgt_r_valid_i  (tgt_r_valid_i),
    .tgt_r_ready_o  (tgt_r_ready_o),
    .tgt_r_data_i   (tgt_r_data_i),
    .tgt_r_id_i     (tgt_r_id_i),
    .tgt_r_resp_i   (tgt_r_resp_i)
  );

  for (genvar j = 0; j < num_targets; j++) begin : gen_tgt
    tb_target_model #(
      .IdWidth     (TgtIdWidth),
      .Delay       (TgtDelay),
      .DataPattern (DataPattern)
    ) u_target_model (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .ar_valid_i (tgt_ar_valid_o[j]),
      .ar_ready_o (tgt_ar_ready_i[j]),
      .ar_addr_i  (tgt_ar_addr_o[j]),
      .ar_id_i    (tgt_ar_id_o[j]),
      .r_valid_o  (tgt_r_valid_i[j]),
      .r_ready_i  (tgt_r_ready_o[j]),
      .r_data_o   (tgt_r_data_i[j]),
      .r_id_o     (tgt_r_id_i[j]),
      .r_resp_o   (tgt_r_resp_i[j])
    );
  end

  // A stalled response must hold until it is taken
  for (genvar i = 0; i < num_requesters; i++) begin : gen_hold
    assert property (@(posedge clk_i) disable iff (rst_i)
      (req_r_valid_o[i] && !req_r_ready_i[i]) |=>
        (req_r_valid_o[i] && $stable(req_r_data_o[i]) && $stable(req_r_id_o[i]) &&
         $stable(req_r_resp_o[i])))
    else begin
      errors++;
      $display("requester %0d response changed while r_ready was low", i);
    end
  end

  function automatic exp_t expected_response(input logic [31:0] addr,
                                             input logic [IdWidth-1:0] id);
    exp_t e;
    e.addr = addr;
    e.id   = id;
    if (addr < 32'h0000_2000) begin
      e.data = addr ^ DataPattern;
      e.resp = RESP_OKAY;
    end else begin
      e.data = '0;
      e.resp = RESP_DECERR;
    end
    return e;
  endfunction

  // True if target j may carry this AR with the right window and a matching read pending
  function automatic logic ar_is_pending(input int j, input logic [31:0] addr,
                                         input logic [TgtIdWidth-1:0] tid);
    int r;
    logic hit;
    r   = int'(tid[TgtIdWidth-1]);
    hit = 1'b0;
    for (int k = 0; k < exp_q[r].size(); k++) begin
      if (exp_q[r][k].addr == addr && exp_q[r][k].id == tid[IdWidth-1:0]) begin
        hit = 1'b1;
      end
    end
    return hit && (int'(addr / 32'h1000) == j);
  endfunction

  task automatic report_mismatch(input string name, input int r, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("ERR %s[%0d] got 0x%h expected 0x%h", name, r, got, exp);
  endtask

  always @(posedge clk_i) begin
    if (!rst_i) begin
      for (int j = 0; j < num_targets; j++) begin
        if (tgt_ar_valid_o[j] && tgt_ar_ready_i[j]) begin
          tgt_ar_count[j]++;
          assert (ar_is_pending(j, tgt_ar_addr_o[j], tgt_ar_id_o[j])) else begin
            errors++;
            $display("target %0d got AR addr 0x%h id 0x%h that no requester issued",
                     j, tgt_ar_addr_o[j], tgt_ar_id_o[j]);
          end
        end
      end
    end
  end

  // Scoreboard compare on every requester R handshake
  always @(posedge clk_i) begin
    exp_t e;
    if (!rst_i) begin
      for (int i = 0; i < num_requesters; i++) begin
        if (req_r_valid_o[i] && req_r_ready_i[i]) begin
          if (exp_q[i].size() == 0) begin
            errors++;
            $display("requester %0d got a response with no read outstanding", i);
          end else begin
            e = exp_q[i].pop_front();
            assert (req_r_data_o[i] == e.data) else
              report_mismatch("req_r_data_o", i, req_r_data_o[i], e.data);
            assert (req_r_id_o[i] == e.id) else
              report_mismatch("req_r_id_o", i, 32'(req_r_id_o[i]), 32'(e.id));
            assert (req_r_resp_o[i] == e.resp) else
              report_mismatch("req_r_resp_o", i, 32'(req_r_resp_o[i]), 32'(e.resp));
          end
        end
      end
    end
  end

  // Random r_ready per requester on each falling edge while enabled
  task automatic drive_random_ready();
    while (random_ready) begin
      @(negedge clk_i);
      if (random_ready) begin
        req_r_ready_i = 2'($urandom_range(0, 3));
      end else begin
        req_r_ready_i = '1;
      end
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("TEST FAILED");
    $finish;
  endtask

  // Kind 0 and 1 pick target windows and kind 2 an unmapped address
  function automatic logic [31:0] rand_addr(input int kind);
    logic [31:0] offset;
    offset = {20'h0_0000, 10'($urandom_range(0, 1023)), 2'b00};
    if (kind == 0) begin
      return offset;
    end else if (kind == 1) begin
      return 32'h0000_1000 + offset;
    end
    return 32'h0000_3000 + offset;
  endfunction

  function automatic logic [IdWidth-1:0] rand_id();
    return IdWidth'($urandom_range(0, (1 << IdWidth) - 1));
  endfunction

  task automatic issue_read(input int r, input logic [31:0] addr,
                            input logic [IdWidth-1:0] id);
    int waited;
    @(negedge clk_i);
    exp_q[r].push_back(expected_response(addr, id));
    req_ar_valid_i[r] = 1'b1;
    req_ar_addr_i[r]  = addr;
    req_ar_id_i[r]    = id;
    waited = 0;
    @(posedge clk_i);
    while (!req_ar_ready_o[r]) begin
      if (waited == Timeout) fail_timeout("an AR handshake");
      waited++;
      @(posedge clk_i);
    end
    @(negedge clk_i);
    req_ar_valid_i[r] = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      if (waited == Timeout) fail_timeout("outstanding responses");
      waited++;
      @(negedge clk_i);
    end
  endtask

  task automatic close_test(input int num, input string name, input int start_errors);
    if (errors == start_errors) begin
      tests_passed++;
      $display("test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed", num, name);
    end
  endtask

  initial begin
    int start;
    int ar_before;
    errors         = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    random_ready   = 1'b0;
    rst_i          = 1'b1;
    req_ar_valid_i = '0;
    req_ar_addr_i  = '0;
    req_ar_id_i    = '0;
    req_r_ready_i  = '1;
    tgt_ar_count   = '{default: 0};
    void'($urandom(Seed));
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;

    for (int t = 0; t < 2; t++) begin
      start     = errors;
      ar_before = tgt_ar_count[t];
      issue_read(t, rand_addr(t), rand_id());
      wait_drain();
      assert (tgt_ar_count[t] == ar_before + 1) else begin
        errors++;
        $display("target %0d did not receive exactly one AR", t);
      end
      close_test(t + 1, $sformatf("single read to target %0d", t), start);
    end

    start     = errors;
    ar_before = tgt_ar_count[0] + tgt_ar_count[1];
    issue_read(1, rand_addr(2), rand_id());
    wait_drain();
    assert (tgt_ar_count[0] + tgt_ar_count[1] == ar_before) else begin
      errors++;
      $display("an unmapped read reached a target");
    end
    close_test(3, "unmapped read", start);

    start = errors;
    fork
      issue_read(0, rand_addr(1), rand_id());
      issue_read(1, rand_addr(1), rand_id());
    join
    wait_drain();
    close_test(4, "both requesters on one target", start);

    start = errors;
    @(posedge clk_i);
    random_ready = 1'b1;
    fork
      drive_random_ready();
      begin
        for (int k = 0; k < 8; k++) begin
          fork
            issue_read(0, rand_addr($urandom_range(0, 2)), rand_id());
            issue_read(1, rand_addr($urandom_range(0, 2)), rand_id());
          join
        end
        wait_drain();
        @(posedge clk_i);
        random_ready = 1'b0;
      end
    join
    close_test(5, "random r_ready back-pressure", start);

    start = errors;
    for (int k = 0; k < 9; k++) begin
      issue_read(0, rand_addr(k % 3), rand_id());
    end
    wait_drain();
    close_test(6, "alternating destinations in order", start);

    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
hw/xbar_pkg.sv
hw/addr_decoder.sv
hw/read_demux.sv
hw/decerr_responder.sv
hw/read_mux.sv
hw/read_xbar.sv
verification/tb_target_model.sv
verification/tb_read_xbar.sv

//--- Bender.yml
package:
  name: read_xbar

sources:
  - hw/xbar_pkg.sv
  - hw/addr_decoder.sv
  - hw/read_demux.sv
  - hw/decerr_responder.sv
  - hw/read_mux.sv
  - hw/read_xbar.sv
  - target: test
    files:
      - verification/tb_target_model.sv
      - verification/tb_read_xbar.sv
